//--- source/gf_pkg.sv
// ================================================
// Wishbone request/response structs, register map
// constants and the per-channel status struct
// ================================================
package gf_pkg;

  // Bus geometry
  localparam int WB_ADDR_W = 4;
  localparam int WB_DATA_W = 32;

  // One data word holds one bit per channel
  localparam int MAX_CH = WB_DATA_W;

  // Register map
  localparam logic [WB_ADDR_W-1:0] REG_LEVEL   = 4'h0;
  localparam logic [WB_ADDR_W-1:0] REG_GLITCH  = 4'h1;
  localparam logic [WB_ADDR_W-1:0] REG_CHANGES = 4'h2;

  // Master to slave
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [WB_ADDR_W-1:0] adr;
    logic [WB_DATA_W-1:0] dat_w;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic                 ack;
    logic [WB_DATA_W-1:0] dat_r;
  } wb_rsp_t;

  // Filter result for one channel
  typedef struct packed {
    logic level;
    // One-cycle pulse at the end of a glitched window
    logic glitch;
  } ch_status_t;

endpackage

//--- source/input_sync.sv
// ================================================
// Two-flop synchronizer for the raw input pins
// ================================================
`timescale 1ns/1ns

module input_sync #(
  parameter int NUM_CH        = 8,
  parameter bit DEFAULT_LEVEL = 1'b0
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [NUM_CH-1:0] pins_in,
  output logic [NUM_CH-1:0] pins_sync
);

  logic [NUM_CH-1:0] meta_q;
  logic [NUM_CH-1:0] sync_q;

  // Both stages start at the idle level so the filters
  // see no edge when reset is released
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      meta_q <= {NUM_CH{DEFAULT_LEVEL}};
      sync_q <= {NUM_CH{DEFAULT_LEVEL}};
    end else begin
      meta_q <= pins_in;
      sync_q <= meta_q;
    end
  end

  assign pins_sync = sync_q;

endmodule

//--- source/glitch_filter.sv
// ================================================
// Windowed glitch filter for one channel
// ================================================
`timescale 1ns/1ns

module glitch_filter
  import gf_pkg::*;
#(
  parameter int WINDOW_LEN    = 8,
  parameter bit DEFAULT_LEVEL = 1'b0
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       sample,
  output ch_status_t status
);

  // Wide enough for 0 .. WINDOW_LEN-1
  localparam int TMR_W = (WINDOW_LEN > 1) ? $clog2(WINDOW_LEN) : 1;
  localparam logic [TMR_W-1:0] TMR_LAST = TMR_W'(WINDOW_LEN - 1);

  logic [TMR_W-1:0] timer_q;
  logic [1:0]       hist_q;
  logic             glitch_q;
  logic             level_q;
  logic             pulse_q;
  logic             window_end;

  assign window_end = (timer_q == TMR_LAST);

  // Free-running window timer
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      timer_q <= '0;
    end else if (window_end) begin
      timer_q <= '0;
    end else begin
      timer_q <= timer_q + 1'b1;
    end
  end

  // History shifts inside the window and holds on the last cycle.
  // A 1 followed by a 0 marks the window as glitched.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hist_q   <= 2'b00;
      glitch_q <= 1'b0;
    end else if (window_end) begin
      glitch_q <= 1'b0;
    end else begin
      hist_q <= {hist_q[0], sample};
      if (hist_q == 2'b10) begin
        glitch_q <= 1'b1;
      end
    end
  end

  // Output update once per window
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      level_q <= DEFAULT_LEVEL;
      pulse_q <= 1'b0;
    end else if (window_end) begin
      level_q <= glitch_q ? DEFAULT_LEVEL : sample;
      pulse_q <= glitch_q;
    end else begin
      pulse_q <= 1'b0;
    end
  end

  assign status.level  = level_q;
  assign status.glitch = pulse_q;

endmodule

//--- source/wb_status_regs.sv
// ================================================
// Wishbone classic slave with level, sticky glitch
// and change-count registers
// ================================================
`timescale 1ns/1ns

module wb_status_regs
  import gf_pkg::*;
#(
  parameter int NUM_CH = 8
) (
  input  logic       clk,
  input  logic       arst_n,
  input  wb_req_t    wb_req,
  output wb_rsp_t    wb_rsp,
  input  ch_status_t ch_status [NUM_CH]
);

  logic [MAX_CH-1:0]    level_vec;
  logic [NUM_CH-1:0]    pulse_vec;
  logic [NUM_CH-1:0]    level_prev_q;
  logic                 prev_valid_q;
  logic                 changed;
  logic [NUM_CH-1:0]    glitch_q;
  logic [NUM_CH-1:0]    clr_mask;
  logic [15:0]          change_cnt_q;
  logic                 cnt_clr;
  logic                 ack_q;
  logic                 access;
  logic                 wr_access;
  logic [WB_DATA_W-1:0] rd_data;
  logic [WB_DATA_W-1:0] dat_r_q;

  // Gather the per-channel levels and glitch pulses
  always_comb begin
    level_vec = '0;
    pulse_vec = '0;
    for (int i = 0; i < NUM_CH; i++) begin
      level_vec[i] = ch_status[i].level;
      pulse_vec[i] = ch_status[i].glitch;
    end
  end

  // Bus decode

  // The cycle after an ack takes no new access
  assign access    = wb_req.cyc && wb_req.stb && !ack_q;
  assign wr_access = access && wb_req.we;

  assign clr_mask = (wr_access && wb_req.adr == REG_GLITCH) ?
                    wb_req.dat_w[NUM_CH-1:0] : '0;
  assign cnt_clr  = wr_access && (wb_req.adr == REG_CHANGES);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // Change detection

  // Previous levels are compared only once they hold real data
  always_ff @(posedge clk) begin
    level_prev_q <= level_vec[NUM_CH-1:0];
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prev_valid_q <= 1'b0;
    end else begin
      prev_valid_q <= 1'b1;
    end
  end

  assign changed = prev_valid_q && (level_vec[NUM_CH-1:0] != level_prev_q);

  // A change in the clearing cycle still counts
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      change_cnt_q <= '0;
    end else if (cnt_clr) begin
      change_cnt_q <= 16'(changed);
    end else begin
      change_cnt_q <= change_cnt_q + 16'(changed);
    end
  end

  // Sticky glitch flags where a set beats a clear
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      glitch_q <= '0;
    end else begin
      glitch_q <= (glitch_q & ~clr_mask) | pulse_vec;
    end
  end

  // Read path

  always_comb begin
    case (wb_req.adr)
      REG_LEVEL:   rd_data = WB_DATA_W'(level_vec);
      REG_GLITCH:  rd_data = WB_DATA_W'(glitch_q);
      REG_CHANGES: rd_data = WB_DATA_W'(change_cnt_q);
      default:     rd_data = '0;
    endcase
  end

  // Captured with the ack so it stays valid while ack is high
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dat_r_q <= '0;
    end else if (access && !wb_req.we) begin
      dat_r_q <= rd_data;
    end
  end

  assign wb_rsp.ack   = ack_q;
  assign wb_rsp.dat_r = dat_r_q;

endmodule

//--- source/glitch_monitor_top.sv
// ================================================
// Input conditioner top: synchronizer, per-channel
// glitch filters and Wishbone register block
// ================================================
`timescale 1ns/1ns

module glitch_monitor_top
  import gf_pkg::*;
#(
  parameter int NUM_CH        = 8,
  parameter int WINDOW_LEN    = 8,
  parameter bit DEFAULT_LEVEL = 1'b0
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [NUM_CH-1:0] pins_in,
  input  wb_req_t           wb_req,
  output wb_rsp_t           wb_rsp
);

  logic [NUM_CH-1:0] pins_sync;
  ch_status_t        ch_status [NUM_CH];

  // Bring the raw pins into the clock domain
  input_sync #(
    .NUM_CH        (NUM_CH),
    .DEFAULT_LEVEL (DEFAULT_LEVEL)
  ) u_sync (
    .clk       (clk),
    .arst_n    (arst_n),
    .pins_in   (pins_in),
    .pins_sync (pins_sync)
  );

  // One filter per channel
  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch
    glitch_filter #(
      .WINDOW_LEN    (WINDOW_LEN),
      .DEFAULT_LEVEL (DEFAULT_LEVEL)
    ) u_filter (
      .clk    (clk),
      .arst_n (arst_n),
      .sample (pins_sync[ch]),
      .status (ch_status[ch])
    );
  end

  // Register readout
  wb_status_regs #(
    .NUM_CH (NUM_CH)
  ) u_regs (
    .clk       (clk),
    .arst_n    (arst_n),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .ch_status (ch_status)
  );

endmodule

//--- sim/tb_wb_tasks.svh
// ==================================================
// Wishbone classic master tasks, register compare
// and the xorshift generator for the testbench
// ==================================================

// Next state of a 32-bit xorshift generator
function automatic logic [31:0] xorshift32(input logic [31:0] state);
  logic [31:0] x;
  x = state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// Waits for the ack of the access on the bus, releases the bus
// and makes sure ack drops again one cycle later
task automatic finish_access(output logic [WB_DATA_W-1:0] data);
  int waited;
  waited = 0;
  do begin
    @(posedge clk);
    #DRIVE_DLY;
    waited++;
  end while (!wb_rsp.ack && waited < ACK_LIMIT);
  assert (wb_rsp.ack) else begin
    $display("Wishbone access to address %h got no ack within %0d cycles",
             wb_req.adr, ACK_LIMIT);
    proto_errs++;
  end
  assert (waited == 1) else begin
    $display("Wishbone ack came %0d cycles after stb instead of 1", waited);
    proto_errs++;
  end
  data   = wb_rsp.dat_r;
  wb_req = '0;
  @(posedge clk);
  #DRIVE_DLY;
  assert (!wb_rsp.ack) else begin
    $display("Wishbone ack stayed high for more than one cycle");
    proto_errs++;
  end
endtask

task automatic wb_write(input logic [WB_ADDR_W-1:0] adr,
                        input logic [WB_DATA_W-1:0] data);
  logic [WB_DATA_W-1:0] unused_rd;
  wb_req.cyc   = 1'b1;
  wb_req.stb   = 1'b1;
  wb_req.we    = 1'b1;
  wb_req.adr   = adr;
  wb_req.dat_w = data;
  finish_access(unused_rd);
endtask

task automatic wb_read(input logic [WB_ADDR_W-1:0] adr,
                       output logic [WB_DATA_W-1:0] data);
  wb_req.cyc   = 1'b1;
  wb_req.stb   = 1'b1;
  wb_req.we    = 1'b0;
  wb_req.adr   = adr;
  wb_req.dat_w = '0;
  finish_access(data);
endtask

// Read one register and compare it with the expected word
task automatic check_reg(input logic [WB_ADDR_W-1:0] adr, input string name,
                         input logic [WB_DATA_W-1:0] expected);
  logic [WB_DATA_W-1:0] got;
  wb_read(adr, got);
  assert (got === expected) else begin
    $display("ERROR %s expected %h got %h", name, expected, got);
    value_errs++;
  end
endtask

//--- sim/tb_glitch_monitor.sv
// ==================================================
// Testbench for the glitch monitor: clock, reset,
// stimulus phases, checks and the closing report
// ==================================================
`timescale 1ns/1ns

module tb_glitch_monitor
  import gf_pkg::*;
();

  localparam int NUM_CH        = 8;
  localparam int WINDOW_LEN    = 8;
  localparam bit DEFAULT_LEVEL = 1'b0;
  localparam int CLK_PERIOD    = 100;
  localparam int DRIVE_DLY     = 10;
  localparam int ACK_LIMIT     = 8;
  localparam int HOLD_CYC      = 3 * WINDOW_LEN;
  localparam int NUM_PATTERNS  = 12;
  localparam logic [31:0] SEED = 32'hee4e57ce;

  // Channels hit by a short low pulse, and the flags cleared first
  localparam logic [NUM_CH-1:0] PULSE_MASK = 8'h25;
  localparam logic [NUM_CH-1:0] CLEAR_MASK = 8'h21;

  // Cycle budget per phase, one access takes two cycles
  localparam int ACCESS_CYC = 2;
  localparam int TEST_CYC   = 7 + 7 * ACCESS_CYC
                            + NUM_PATTERNS * (HOLD_CYC + ACCESS_CYC) + ACCESS_CYC
                            + HOLD_CYC + 5 * ACCESS_CYC + 2 * WINDOW_LEN + 2
                            + HOLD_CYC + 7 * ACCESS_CYC;
  localparam int CYCLE_LIMIT = TEST_CYC + TEST_CYC / 5;

  logic              clk;
  logic              arst_n;
  logic [NUM_CH-1:0] pins_in;
  wb_req_t           wb_req;
  wb_rsp_t           wb_rsp;

  int value_errs  = 0;
  int proto_errs  = 0;
  int assert_errs = 0;
  int cycle_cnt   = 0;
  int win_pos     = 0;

  `include "tb_wb_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  glitch_monitor_top #(
    .NUM_CH        (NUM_CH),
    .WINDOW_LEN    (WINDOW_LEN),
    .DEFAULT_LEVEL (DEFAULT_LEVEL)
  ) u_dut (
    .clk     (clk),
    .arst_n  (arst_n),
    .pins_in (pins_in),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp)
  );

  // Position inside the filter window, counted like the window timer
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      win_pos <= 0;
    end else if (win_pos == WINDOW_LEN - 1) begin
      win_pos <= 0;
    end else begin
      win_pos <= win_pos + 1;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles before the test sequence ended", cycle_cnt);
      $display("Errors: %0d value, %0d protocol, %0d assertion",
               value_errs, proto_errs, assert_errs);
      $display("test failed");
      $finish;
    end
  end

  rsp_known: assert property (@(posedge clk) disable iff (!arst_n)
      !$isunknown(wb_rsp))
    else begin
      $display("Wishbone response holds unknown bits after reset release");
      assert_errs++;
    end

  // No ack unless a request was on the bus the cycle before
  ack_after_req: assert property (@(posedge clk) disable iff (!arst_n)
      wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
    else begin
      $display("Wishbone ack appeared without a request");
      assert_errs++;
    end

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #DRIVE_DLY;
  endtask

  // Stops just after the edge that moves the window to pos
  task automatic wait_window_pos(input int pos);
    do begin
      @(posedge clk);
      #DRIVE_DLY;
    end while (win_pos != pos);
  endtask

  initial begin
    logic [31:0]       rng;
    logic [NUM_CH-1:0] pattern;
    logic [NUM_CH-1:0] prev_pattern;
    logic [NUM_CH-1:0] exp_level;
    int                exp_changes;

    arst_n       = 1'b0;
    pins_in      = {NUM_CH{DEFAULT_LEVEL}};
    wb_req       = '0;
    rng          = SEED;
    prev_pattern = {NUM_CH{DEFAULT_LEVEL}};
    exp_changes  = 0;
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    arst_n = 1'b1;

    // Reset state, bus idle
    repeat (4) begin
      @(posedge clk);
      #DRIVE_DLY;
      assert (!wb_rsp.ack) else begin
        $display("Wishbone ack went high with no access on the bus");
        proto_errs++;
      end
    end
    check_reg(REG_LEVEL, "REG_LEVEL", WB_DATA_W'({NUM_CH{DEFAULT_LEVEL}}));
    check_reg(REG_GLITCH, "REG_GLITCH", '0);
    check_reg(REG_CHANGES, "REG_CHANGES", '0);

    // Read-only level register and unmapped addresses
    wb_write(REG_LEVEL, '1);
    check_reg(REG_LEVEL, "REG_LEVEL", WB_DATA_W'({NUM_CH{DEFAULT_LEVEL}}));
    check_reg(4'h3, "dat_r at 0x3", '0);
    check_reg(4'hf, "dat_r at 0xf", '0);

    // Random steady patterns, three windows each
    for (int p = 0; p < NUM_PATTERNS; p++) begin
      rng     = xorshift32(rng);
      pattern = rng[NUM_CH-1:0];
      if (pattern != prev_pattern) begin
        exp_changes++;
      end
      pins_in = pattern;
      wait_cycles(HOLD_CYC);
      check_reg(REG_LEVEL, "REG_LEVEL", WB_DATA_W'(pattern));
      prev_pattern = pattern;
    end
    check_reg(REG_CHANGES, "REG_CHANGES", WB_DATA_W'(exp_changes));

    // All high, then a short low pulse on some channels mid window
    pins_in = '1;
    if (prev_pattern != '1) begin
      exp_changes++;
    end
    wait_cycles(HOLD_CYC);
    // Falling patterns above left flags behind
    wb_write(REG_GLITCH, '1);
    check_reg(REG_GLITCH, "REG_GLITCH", '0);
    check_reg(REG_LEVEL, "REG_LEVEL", WB_DATA_W'(pins_in));
    wait_window_pos(1);
    pins_in = ~PULSE_MASK;
    wait_cycles(2);
    pins_in = '1;
    wait_window_pos(0);
    exp_level = DEFAULT_LEVEL ? {NUM_CH{1'b1}} : ~PULSE_MASK;
    check_reg(REG_LEVEL, "REG_LEVEL", WB_DATA_W'(exp_level));
    check_reg(REG_GLITCH, "REG_GLITCH", WB_DATA_W'(PULSE_MASK));
    if (!DEFAULT_LEVEL) begin
      // Down at the glitched window end, up again one window later
      exp_changes += 2;
    end

    // Partial and full flag clears, then the counter clear
    wait_cycles(HOLD_CYC);
    check_reg(REG_CHANGES, "REG_CHANGES", WB_DATA_W'(exp_changes));
    wb_write(REG_GLITCH, WB_DATA_W'(CLEAR_MASK));
    check_reg(REG_GLITCH, "REG_GLITCH", WB_DATA_W'(PULSE_MASK & ~CLEAR_MASK));
    wb_write(REG_GLITCH, WB_DATA_W'(PULSE_MASK));
    check_reg(REG_GLITCH, "REG_GLITCH", '0);
    wb_write(REG_CHANGES, '0);
    check_reg(REG_CHANGES, "REG_CHANGES", '0);

    $display("Errors: %0d value, %0d protocol, %0d assertion",
             value_errs, proto_errs, assert_errs);
    if (value_errs == 0 && proto_errs == 0 && assert_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+sim
source/gf_pkg.sv
source/input_sync.sv
source/glitch_filter.sv
source/wb_status_regs.sv
source/glitch_monitor_top.sv
sim/tb_glitch_monitor.sv

//--- run_sim.sh
#!/bin/sh
# Compile the glitch monitor testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_glitch_monitor --Mdir obj_dir -o tb_glitch_monitor \
  -f filelist.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

output=$(./obj_dir/tb_glitch_monitor 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# The run counts as good only when the pass line shows up
if printf '%s\n' "$output" | grep -qx "test passed"; then
  exit 0
fi

echo "Pass line not found in the simulation output"
exit 1
